//--- all.f
src/mac_pkg.sv
src/mul_add.sv
src/cmd_fifo.sv
src/mac_ctrl.sv
src/mac_top.sv
sim/mac_checker.sv
sim/tb_mac_top.sv

//--- Makefile
# Verilator build and run for the multiply-accumulate engine

VERILATOR ?= verilator
TOP       ?= tb_mac_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation passed

SOURCES   := $(wildcard src/*.sv sim/*.sv)
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS: $(TOP)"; \
	else \
		echo "FAIL: $(TOP), see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_mac_top.sv
// --------------------------------------------------------------------------
// testbench for the multiply-accumulate engine
// directed and random command groups checked against a software model
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mac_top;

    import mac_pkg::*;

    localparam int a_width     = default_a_width;
    localparam int b_width     = default_b_width;
    localparam int c_width     = default_c_width;
    localparam int p_width     = default_p_width;
    localparam int fifo_depth  = default_fifo_depth;
    localparam int rand_groups = 24;
    // all tests need well under 800 cycles, random gaps included
    localparam int max_cycles  = 4000;

    logic                      clk;
    logic                      reset;
    logic                      cmd_valid;
    mac_op_t                   cmd_op;
    logic signed [a_width-1:0] cmd_a;
    logic signed [b_width-1:0] cmd_b;
    logic signed [c_width-1:0] cmd_c;
    logic                      cmd_last;
    logic                      cmd_credit;
    logic                      res_credit;
    logic                      res_valid;
    logic signed [p_width-1:0] res_data;

    int                        cmds_sent;
    int                        lasts_sent;
    int                        credit_pulses;
    int                        results_seen;
    int                        pass_cnt;
    int                        err_cnt;
    int                        total_errs;
    int                        cycles;
    logic [31:0]               lcg_state;
    logic signed [p_width-1:0] model_sum;
    logic signed [p_width-1:0] exp_q [$];

    mac_top #(
        .a_width    (a_width),
        .b_width    (b_width),
        .c_width    (c_width),
        .p_width    (p_width),
        .fifo_depth (fifo_depth)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_a      (cmd_a),
        .cmd_b      (cmd_b),
        .cmd_c      (cmd_c),
        .cmd_last   (cmd_last),
        .cmd_credit (cmd_credit),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res_data   (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", max_cycles);
        $display("Simulation failed");
        $finish;
    end

    // --------------------------------------------------------------------------
    // helpers
    // --------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int credits_held();
        return fifo_depth - cmds_sent + credit_pulses;
    endfunction

    task automatic check_value(input string name, input logic [p_width-1:0] exp,
                               input logic [p_width-1:0] got);
        if (exp !== got) begin
            $display("mismatch %s exp=%h got=%h", name, exp, got);
            err_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // credits and results, sampled on the falling edge
    task automatic watch_outputs();
        forever begin
            @(negedge clk);
            if (cmd_credit) credit_pulses++;
            if (res_valid) begin
                results_seen++;
                if (exp_q.size() == 0) begin
                    $display("result %h arrived with no result outstanding", res_data);
                    err_cnt++;
                end else begin
                    check_value("res_data", exp_q.pop_front(), res_data);
                end
            end
        end
    endtask

    task automatic send_cmd(input mac_op_t op, input logic signed [a_width-1:0] a,
                            input logic signed [b_width-1:0] b,
                            input logic signed [c_width-1:0] c, input logic last);
        logic signed [p_width-1:0] prod;
        logic signed [p_width-1:0] c_ext;
        prod  = p_width'(a) * p_width'(b);
        c_ext = p_width'(c);
        case (op)
            op_load_add: model_sum = c_ext + prod;
            op_load_sub: model_sum = c_ext - prod;
            op_acc_add:  model_sum = model_sum + prod;
            default:     model_sum = model_sum - prod;
        endcase
        if (last) begin
            exp_q.push_back(model_sum);
            lasts_sent++;
        end
        while (credits_held() == 0) begin
            @(posedge clk);
            #1;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_a     = a;
        cmd_b     = b;
        cmd_c     = c;
        cmd_last  = last;
        cmds_sent++;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // one load, then accumulate steps, the final one marked last
    task automatic send_group(input int len, input logic any_op);
        int          i;
        mac_op_t     op;
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        for (i = 0; i < len; i++) begin
            r  = lcg_next();
            hi = lcg_next();
            lo = lcg_next();
            if (i == 0) begin
                if (r[31]) op = op_load_sub;
                else op = op_load_add;
            end else if (any_op) begin
                op = mac_op_t'(r[31:30]);
            end else begin
                if (r[31]) op = op_acc_sub;
                else op = op_acc_add;
            end
            send_cmd(op, a_width'(hi >> 14), b_width'(lo >> 14), c_width'({hi, lo}),
                     i == len - 1);
        end
    endtask

    task automatic grant_credits(input int n);
        repeat (n) begin
            res_credit = 1'b1;
            @(posedge clk);
            #1;
        end
        res_credit = 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    // --------------------------------------------------------------------------
    // tests
    // --------------------------------------------------------------------------
    task automatic test_single();
        int                        errs;
        logic signed [a_width-1:0] a_min;
        logic signed [a_width-1:0] a_max;
        logic signed [b_width-1:0] b_min;
        logic signed [b_width-1:0] b_max;
        errs  = err_cnt;
        a_min = {1'b1, {(a_width-1){1'b0}}};
        a_max = {1'b0, {(a_width-1){1'b1}}};
        b_min = {1'b1, {(b_width-1){1'b0}}};
        b_max = {1'b0, {(b_width-1){1'b1}}};
        grant_credits(4);
        send_cmd(op_load_add, a_min, b_min, c_width'(-1000), 1'b1);
        send_cmd(op_load_sub, a_min, b_min, c_width'(77), 1'b1);
        send_cmd(op_load_add, a_max, b_min, c_width'(0), 1'b1);
        send_cmd(op_load_sub, a_max, b_max, c_width'(-5), 1'b1);
        wait_results();
        report_test("single load commands", errs);
    endtask

    task automatic test_groups();
        int errs;
        errs = err_cnt;
        grant_credits(3);
        send_group(5, 1'b0);
        send_group(3, 1'b0);
        send_group(7, 1'b0);
        wait_results();
        report_test("accumulate groups", errs);
    endtask

    task automatic test_backpressure();
        int          errs;
        int          seen;
        int          i;
        mac_op_t     op;
        logic [31:0] r;
        errs = err_cnt;
        seen = results_seen;
        for (i = 0; i < fifo_depth; i++) begin
            r = lcg_next();
            if (r[31]) op = op_load_sub;
            else op = op_load_add;
            send_cmd(op, a_width'(r >> 14), b_width'(r), c_width'(i), 1'b1);
        end
        repeat (20) @(posedge clk);
        #1;
        check_value("results while held", p_width'(seen), p_width'(results_seen));
        check_value("sender credits", p_width'(0), p_width'(credits_held()));
        grant_credits(fifo_depth);
        wait_results();
        check_value("results after grant", p_width'(fifo_depth),
                    p_width'(results_seen - seen));
        report_test("result back-pressure", errs);
    endtask

    task automatic test_credit_count();
        int errs;
        int pulses;
        int sent;
        errs   = err_cnt;
        pulses = credit_pulses;
        sent   = cmds_sent;
        grant_credits(2);
        send_group(6, 1'b0);
        send_group(8, 1'b0);
        wait_results();
        check_value("cmd_credit pulses", p_width'(cmds_sent - sent),
                    p_width'(credit_pulses - pulses));
        check_value("sender credits", p_width'(fifo_depth), p_width'(credits_held()));
        report_test("command credit accounting", errs);
    endtask

    task automatic test_random();
        int errs;
        int seen;
        int lasts;
        int i;
        int j;
        int gaps [rand_groups];
        int lens [rand_groups];
        errs  = err_cnt;
        seen  = results_seen;
        lasts = lasts_sent;
        for (i = 0; i < rand_groups; i++) begin
            gaps[i] = int'(lcg_next() >> 28);
            lens[i] = 1 + int'(lcg_next() >> 29);
        end
        fork
            begin
                for (i = 0; i < rand_groups; i++) send_group(lens[i], 1'b1);
            end
            begin
                for (j = 0; j < rand_groups; j++) begin
                    repeat (gaps[j]) @(posedge clk);
                    #1;
                    grant_credits(1);
                end
            end
        join
        wait_results();
        check_value("result count", p_width'(lasts_sent - lasts),
                    p_width'(results_seen - seen));
        report_test("random groups", errs);
    endtask

    // --------------------------------------------------------------------------
    // main sequence
    // --------------------------------------------------------------------------
    initial begin
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd_op        = op_load_add;
        cmd_a         = '0;
        cmd_b         = '0;
        cmd_c         = '0;
        cmd_last      = 1'b0;
        res_credit    = 1'b0;
        cmds_sent     = 0;
        lasts_sent    = 0;
        credit_pulses = 0;
        results_seen  = 0;
        pass_cnt      = 0;
        err_cnt       = 0;
        lcg_state     = 32'd48;
        model_sum     = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            watch_outputs();
        join_none
        test_single();
        test_groups();
        test_backpressure();
        test_credit_count();
        test_random();
        total_errs = err_cnt + i_dut.i_mac_checker.fail_count;
        $display("checks passed: %0d, errors: %0d", pass_cnt, total_errs);
        if (total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mac_checker.sv
// --------------------------------------------------------------------------
// mac checker
// credit and handshake assertions, bound to the top level
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mac_checker #(
    parameter int fifo_depth = mac_pkg::default_fifo_depth
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic cmd_valid,
    input wire logic cmd_credit,
    input wire logic pop,
    input wire logic entry_last,
    input wire logic res_valid
);

    import mac_pkg::*;

    int held;
    int fail_credit  = 0;
    int fail_return  = 0;
    int fail_reset   = 0;
    int fail_latency = 0;
    int fail_count;

    assign fail_count = fail_credit + fail_return + fail_reset + fail_latency;

    // credits held by the sender
    always_ff @(posedge clk) begin
        if (reset) begin
            held <= fifo_depth;
        end else begin
            held <= held - int'(cmd_valid) + int'(cmd_credit);
        end
    end

    a_push_credit: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> held > 0)
    else begin
        fail_credit++;
        $error("command pushed with no credit held");
    end

    a_credit_pop: assert property (@(posedge clk) disable iff (reset)
        cmd_credit |-> $past(pop))
    else begin
        fail_return++;
        $error("cmd_credit pulsed without a pop");
    end

    a_reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> !cmd_credit && !res_valid)
    else begin
        fail_reset++;
        $error("cmd_credit or res_valid active around reset");
    end

    a_latency: assert property (@(posedge clk) disable iff (reset)
        res_valid == $past(pop && entry_last, pipe_stages))
    else begin
        fail_latency++;
        $error("result not exactly four cycles after a last pop");
    end

endmodule

bind mac_top mac_checker #(
    .fifo_depth (fifo_depth)
) i_mac_checker (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_credit (cmd_credit),
    .pop        (pop),
    .entry_last (entry_last),
    .res_valid  (res_valid)
);

`default_nettype wire

//--- src/mac_top.sv
// --------------------------------------------------------------------------
// mac top
// command buffer, controller and multiply-add cell
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mac_top #(
    parameter int a_width    = mac_pkg::default_a_width,
    parameter int b_width    = mac_pkg::default_b_width,
    parameter int c_width    = mac_pkg::default_c_width,
    parameter int p_width    = mac_pkg::default_p_width,
    parameter int fifo_depth = mac_pkg::default_fifo_depth
) (
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      cmd_valid,
    input  wire mac_pkg::mac_op_t          cmd_op,
    input  wire logic signed [a_width-1:0] cmd_a,
    input  wire logic signed [b_width-1:0] cmd_b,
    input  wire logic signed [c_width-1:0] cmd_c,
    input  wire logic                      cmd_last,
    output logic                           cmd_credit,

    input  wire logic                      res_credit,
    output logic                           res_valid,
    output logic signed      [p_width-1:0] res_data
);

    import mac_pkg::*;

    logic                      pop;
    logic                      entry_valid;
    mac_op_t                   entry_op;
    logic signed [a_width-1:0] entry_a;
    logic signed [b_width-1:0] entry_b;
    logic signed [c_width-1:0] entry_c;
    logic                      entry_last;

    logic                      cke_ctrl;
    logic                      cke_alumode;
    logic                      cke_a0;
    logic                      cke_a1;
    logic                      cke_b0;
    logic                      cke_b1;
    logic                      cke_c;
    logic                      cke_m;
    logic                      cke_p;
    logic                      op_load;
    logic                      alu_sub;
    logic signed [c_width-1:0] c_stage;

    cmd_fifo #(
        .a_width    (a_width),
        .b_width    (b_width),
        .c_width    (c_width),
        .fifo_depth (fifo_depth)
    ) i_cmd_fifo (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_a       (cmd_a),
        .cmd_b       (cmd_b),
        .cmd_c       (cmd_c),
        .cmd_last    (cmd_last),
        .cmd_credit  (cmd_credit),
        .pop         (pop),
        .entry_valid (entry_valid),
        .entry_op    (entry_op),
        .entry_a     (entry_a),
        .entry_b     (entry_b),
        .entry_c     (entry_c),
        .entry_last  (entry_last)
    );

    mac_ctrl #(
        .c_width (c_width)
    ) i_mac_ctrl (
        .clk         (clk),
        .reset       (reset),
        .entry_valid (entry_valid),
        .entry_op    (entry_op),
        .entry_c     (entry_c),
        .entry_last  (entry_last),
        .pop         (pop),
        .res_credit  (res_credit),
        .cke_ctrl    (cke_ctrl),
        .cke_alumode (cke_alumode),
        .cke_a0      (cke_a0),
        .cke_a1      (cke_a1),
        .cke_b0      (cke_b0),
        .cke_b1      (cke_b1),
        .cke_c       (cke_c),
        .cke_m       (cke_m),
        .cke_p       (cke_p),
        .op_load     (op_load),
        .alu_sub     (alu_sub),
        .c_stage     (c_stage),
        .res_valid   (res_valid)
    );

    mul_add #(
        .a_width (a_width),
        .b_width (b_width),
        .c_width (c_width),
        .p_width (p_width)
    ) i_mul_add (
        .clk         (clk),
        .reset       (reset),
        .cke_ctrl    (cke_ctrl),
        .cke_alumode (cke_alumode),
        .cke_a0      (cke_a0),
        .cke_a1      (cke_a1),
        .cke_b0      (cke_b0),
        .cke_b1      (cke_b1),
        .cke_c       (cke_c),
        .cke_m       (cke_m),
        .cke_p       (cke_p),
        .op_load     (op_load),
        .alu_sub     (alu_sub),
        .a           (entry_a),
        .b           (entry_b),
        .c           (c_stage),
        .p           (res_data)
    );

endmodule

`default_nettype wire

//--- src/mac_ctrl.sv
// --------------------------------------------------------------------------
// mac controller
// issues commands, drives the cell enables and frames the results
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mac_ctrl #(
    parameter int c_width = mac_pkg::default_c_width
) (
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      entry_valid,
    input  wire mac_pkg::mac_op_t          entry_op,
    input  wire logic signed [c_width-1:0] entry_c,
    input  wire logic                      entry_last,
    output logic                           pop,

    input  wire logic                      res_credit,

    output logic                           cke_ctrl,
    output logic                           cke_alumode,
    output logic                           cke_a0,
    output logic                           cke_a1,
    output logic                           cke_b0,
    output logic                           cke_b1,
    output logic                           cke_c,
    output logic                           cke_m,
    output logic                           cke_p,
    output logic                           op_load,
    output logic                           alu_sub,
    output logic signed      [c_width-1:0] c_stage,

    output logic                           res_valid
);

    import mac_pkg::*;

    // room for more granted slots than the receiver will ever hold
    localparam int credit_width = 8;

    logic                      issue;
    logic                      consume;
    logic [credit_width-1:0]   credit_cnt;
    logic [pipe_stages-1:0]    valid_sr;
    logic [pipe_stages-1:0]    last_sr;
    mac_op_t                   op_s0;
    mac_op_t                   op_s1;
    logic signed [c_width-1:0] c_s0;
    logic signed [c_width-1:0] c_s1;

    // --------------------------------------------------------------------------
    // issue
    // --------------------------------------------------------------------------
    // a last command waits for an output credit
    assign issue   = entry_valid && (!entry_last || credit_cnt != '0);
    assign consume = issue && entry_last;
    assign pop     = issue;

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= '0;
        end else begin
            case ({res_credit, consume})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // valid and last chain
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
            last_sr  <= '0;
        end else begin
            valid_sr <= {valid_sr[pipe_stages-2:0], issue};
            last_sr  <= {last_sr[pipe_stages-2:0], consume};
        end
    end

    // opcode and addend, two cycles to the product stage
    always_ff @(posedge clk) begin
        if (reset) begin
            op_s0 <= op_load_add;
            op_s1 <= op_load_add;
        end else begin
            if (issue)       op_s0 <= entry_op;
            if (valid_sr[0]) op_s1 <= op_s0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue)       c_s0 <= entry_c;
        if (valid_sr[0]) c_s1 <= c_s0;
    end

    // --------------------------------------------------------------------------
    // cell controls
    // --------------------------------------------------------------------------
    assign cke_a0      = issue;
    assign cke_b0      = issue;
    assign cke_a1      = valid_sr[0];
    assign cke_b1      = valid_sr[0];
    assign cke_m       = valid_sr[1];
    assign cke_c       = valid_sr[1];
    assign cke_ctrl    = valid_sr[1];
    assign cke_alumode = valid_sr[1];
    assign cke_p       = valid_sr[2];

    assign op_load = (op_s1 == op_load_add) || (op_s1 == op_load_sub);
    assign alu_sub = (op_s1 == op_load_sub) || (op_s1 == op_acc_sub);
    assign c_stage = c_s1;

    // result leaves as the last item clears the accumulator stage
    assign res_valid = valid_sr[pipe_stages-1] && last_sr[pipe_stages-1];

endmodule

`default_nettype wire

//--- src/cmd_fifo.sv
// --------------------------------------------------------------------------
// command buffer
// circular command store, one credit returned per popped command
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
    parameter int a_width    = mac_pkg::default_a_width,
    parameter int b_width    = mac_pkg::default_b_width,
    parameter int c_width    = mac_pkg::default_c_width,
    parameter int fifo_depth = mac_pkg::default_fifo_depth
) (
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      cmd_valid,
    input  wire mac_pkg::mac_op_t          cmd_op,
    input  wire logic signed [a_width-1:0] cmd_a,
    input  wire logic signed [b_width-1:0] cmd_b,
    input  wire logic signed [c_width-1:0] cmd_c,
    input  wire logic                      cmd_last,
    output logic                           cmd_credit,

    input  wire logic                      pop,
    output logic                           entry_valid,
    output mac_pkg::mac_op_t               entry_op,
    output logic signed      [a_width-1:0] entry_a,
    output logic signed      [b_width-1:0] entry_b,
    output logic signed      [c_width-1:0] entry_c,
    output logic                           entry_last
);

    import mac_pkg::*;

    localparam int ptr_width = $clog2(fifo_depth);

    mac_op_t                   op_mem   [fifo_depth];
    logic signed [a_width-1:0] a_mem    [fifo_depth];
    logic signed [b_width-1:0] b_mem    [fifo_depth];
    logic signed [c_width-1:0] c_mem    [fifo_depth];
    logic                      last_mem [fifo_depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign do_pop  = pop && entry_valid;
    assign do_push = cmd_valid && (count != (ptr_width + 1)'(fifo_depth) || do_pop);

    // command storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            op_mem[wr_ptr]   <= cmd_op;
            a_mem[wr_ptr]    <= cmd_a;
            b_mem[wr_ptr]    <= cmd_b;
            c_mem[wr_ptr]    <= cmd_c;
            last_mem[wr_ptr] <= cmd_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count      <= count + do_push - do_pop;
            cmd_credit <= do_pop;
        end
    end

    // head of the buffer
    assign entry_valid = (count != '0);
    assign entry_op    = op_mem[rd_ptr];
    assign entry_a     = a_mem[rd_ptr];
    assign entry_b     = b_mem[rd_ptr];
    assign entry_c     = c_mem[rd_ptr];
    assign entry_last  = last_mem[rd_ptr];

endmodule

`default_nettype wire

//--- src/mul_add.sv
// --------------------------------------------------------------------------
// mul add
// pipelined signed multiply-add cell, each register with its own enable
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_add #(
    parameter int a_width = mac_pkg::default_a_width,
    parameter int b_width = mac_pkg::default_b_width,
    parameter int c_width = mac_pkg::default_c_width,
    parameter int p_width = mac_pkg::default_p_width
) (
    input  wire logic                      clk,
    input  wire logic                      reset,

    input  wire logic                      cke_ctrl,
    input  wire logic                      cke_alumode,
    input  wire logic                      cke_a0,
    input  wire logic                      cke_a1,
    input  wire logic                      cke_b0,
    input  wire logic                      cke_b1,
    input  wire logic                      cke_c,
    input  wire logic                      cke_m,
    input  wire logic                      cke_p,

    input  wire logic                      op_load,
    input  wire logic                      alu_sub,

    input  wire logic signed [a_width-1:0] a,
    input  wire logic signed [b_width-1:0] b,
    input  wire logic signed [c_width-1:0] c,
    output logic signed      [p_width-1:0] p
);

    localparam int m_width = a_width + b_width;

    logic                      load_q;
    logic                      sub_q;
    logic signed [a_width-1:0] a0;
    logic signed [a_width-1:0] a1;
    logic signed [b_width-1:0] b0;
    logic signed [b_width-1:0] b1;
    logic signed [c_width-1:0] c0;
    logic signed [m_width-1:0] m0;
    logic signed [p_width-1:0] p0;

    // --------------------------------------------------------------------------
    // control registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            load_q <= 1'b0;
        end else if (cke_ctrl) begin
            load_q <= op_load;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sub_q <= 1'b0;
        end else if (cke_alumode) begin
            sub_q <= alu_sub;
        end
    end

    // --------------------------------------------------------------------------
    // operand and addend registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            a0 <= '0;
            a1 <= '0;
            b0 <= '0;
            b1 <= '0;
            c0 <= '0;
        end else begin
            if (cke_a0) a0 <= a;
            if (cke_a1) a1 <= a0;
            if (cke_b0) b0 <= b;
            if (cke_b1) b1 <= b0;
            if (cke_c)  c0 <= c;
        end
    end

    // --------------------------------------------------------------------------
    // product and accumulator
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m0 <= '0;
        end else if (cke_m) begin
            m0 <= a1 * b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            p0 <= '0;
        end else if (cke_p) begin
            if (load_q) begin
                // new sum from the addend
                p0 <= sub_q ? c0 - m0 : c0 + m0;
            end else begin
                p0 <= sub_q ? p0 - m0 : p0 + m0;
            end
        end
    end

    assign p = p0;

endmodule

`default_nettype wire

//--- src/mac_pkg.sv
// --------------------------------------------------------------------------
// mac package
// opcodes and default sizes for the streaming multiply-accumulate engine
// --------------------------------------------------------------------------
`default_nettype none

package mac_pkg;

    // bit 1 selects accumulate, bit 0 selects subtract
    typedef enum logic [1:0] {
        op_load_add = 2'b00,
        op_load_sub = 2'b01,
        op_acc_add  = 2'b10,
        op_acc_sub  = 2'b11
    } mac_op_t;

    // operand, addend and result widths
    localparam int default_a_width    = 18;
    localparam int default_b_width    = 18;
    localparam int default_c_width    = 48;
    localparam int default_p_width    = 48;

    // command buffer depth, power of two
    localparam int default_fifo_depth = 8;

    // issue to result latency of the multiply-add cell
    localparam int pipe_stages        = 4;

endpackage

`default_nettype wire
